// ==== bench/rv_core_checker.sv ====
module rv_core_checker #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::axi_ar_t   ar,
    input  logic                   arvalid,
    input  logic                   arready,
    input  rv_core_pkg::axi_r_t    r,
    input  logic                   rvalid,
    input  logic                   rready,
    input  logic                   commit_valid,
    input  rv_core_pkg::word_t     commit_pc,
    input  rv_core_pkg::reg_addr_t commit_rd,
    input  rv_core_pkg::word_t     commit_data,
    input  logic                   commit_wen,
    input  logic                   halted,
    input  logic                   fetch_err,
    output int                     error_count,
    output int                     commit_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv_core_pkg::*;

    word_t model_regs [32];
    word_t model_pc;
    word_t fetched_inst;
    word_t fetched_pc;
    word_t ar_addr_q;
    logic  armed = 1'b0;
    logic  first_cycle;
    logic  in_flight;
    logic  fetched;
    logic  stopped;
    logic  stop_by_err;
    logic  ar_wait;
    int    errors = 0;
    int    commits = 0;

    assign error_count  = errors;
    assign commit_count = commits;

    task automatic report_problem(input string msg);
        $display("%0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h (at %0t ns)", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h (at %0t ns)", name, got, exp, $time);
            errors++;
        end
    endtask

    // instruction-set model of one retired instruction
    task automatic check_commit();
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      inst;
        word_t      exp_data;
        word_t      exp_next;
        logic       exp_wen;
        inst     = fetched_inst;
        opc      = inst[6:0];
        rd       = inst[11:7];
        f3       = inst[14:12];
        rs1      = inst[19:15];
        rs2      = inst[24:20];
        f7       = inst[31:25];
        exp_wen  = 1'b1;
        exp_data = '0;
        exp_next = fetched_pc + 32'd4;
        if (opc == OPC_IMM_C && f3 == 3'b000) begin
            exp_data = model_regs[rs1] + {{20{inst[31]}}, inst[31:20]};
        end else if (opc == OPC_CALC && f3 == 3'b000 && f7 == 7'b0000000) begin
            exp_data = model_regs[rs1] + model_regs[rs2];
        end else if (opc == OPC_LUI) begin
            exp_data = {inst[31:12], 12'h000};
        end else if (opc == OPC_AUIPC) begin
            exp_data = fetched_pc + {inst[31:12], 12'h000};
        end else if (opc == OPC_JAL) begin
            exp_data = fetched_pc + 32'd4;
            exp_next = fetched_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                     inst[30:21], 1'b0};
        end else begin
            exp_wen = 1'b0;
            // ebreak retires and then stops the core
            if (inst == 32'h0010_0073) begin
                stopped = 1'b1;
            end
        end
        check_word("commit_pc", commit_pc, fetched_pc);
        check_word("commit_rd", {27'd0, commit_rd}, {27'd0, rd});
        check_bit("commit_wen", commit_wen, exp_wen);
        if (exp_wen) begin
            check_word("commit_data", commit_data, exp_data);
            if (rd != 5'd0) begin
                model_regs[rd] = exp_data;
            end
        end
        model_pc = exp_next;
        commits++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            armed = 1'b1;
            check_bit("arvalid", arvalid, 1'b0);
            check_bit("rready", rready, 1'b0);
            check_bit("commit_valid", commit_valid, 1'b0);
            check_bit("halted", halted, 1'b0);
            check_bit("fetch_err", fetch_err, 1'b0);
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_pc    = RESET_PC;
            first_cycle = 1'b1;
            in_flight   = 1'b0;
            fetched     = 1'b0;
            stopped     = 1'b0;
            stop_by_err = 1'b0;
            ar_wait     = 1'b0;
        end else if (armed) begin
            // halt flags follow one cycle after the model stopped
            check_bit("halted", halted, stopped);
            check_bit("fetch_err", fetch_err, stop_by_err);
            if (first_cycle) begin
                check_bit("arvalid", arvalid, 1'b0);
                check_bit("rready", rready, 1'b0);
                check_bit("commit_valid", commit_valid, 1'b0);
                first_cycle = 1'b0;
            end
            if (ar_wait) begin
                if (!arvalid) begin
                    report_problem("arvalid dropped before the AR handshake");
                end else begin
                    check_word("araddr", ar.araddr, ar_addr_q);
                end
            end
            ar_wait   = arvalid && !arready;
            ar_addr_q = ar.araddr;
            if (arvalid && stopped) begin
                report_problem("arvalid raised after the core halted");
            end
            if (arvalid && arready) begin
                if (in_flight) begin
                    report_problem("a second fetch was issued while one is outstanding");
                end
                if (fetched) begin
                    report_problem("a fetch was issued before the last instruction committed");
                end
                check_word("araddr", ar.araddr, model_pc);
                check_word("arprot", {29'd0, ar.arprot}, 32'h4);
                in_flight = 1'b1;
            end
            if (rvalid && rready) begin
                if (!in_flight) begin
                    report_problem("R handshake without an outstanding fetch");
                end
                in_flight = 1'b0;
                if (r.rresp != 2'b00) begin
                    stopped     = 1'b1;
                    stop_by_err = 1'b1;
                end else begin
                    fetched      = 1'b1;
                    fetched_inst = r.rdata;
                    fetched_pc   = model_pc;
                end
            end
            if (commit_valid) begin
                if (!fetched) begin
                    report_problem("commit without a fetched instruction");
                end else begin
                    check_commit();
                end
                fetched = 1'b0;
            end
        end
    end

endmodule

// ==== bench/tb_rv_core.sv ====
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_core_pkg::*;

    localparam word_t RESET_PC       = 32'h8000_0000;
    localparam int    PROG_LEN       = 32;
    localparam int    NUM_TESTS      = 8;
    localparam int    TIMEOUT_CYCLES = NUM_TESTS * PROG_LEN * 20;
    localparam word_t EBREAK_INST    = 32'h0010_0073;

    logic      clk = 1'b0;
    logic      rst_n = 1'b1;
    axi_ar_t   ar;
    logic      arvalid;
    logic      arready = 1'b0;
    axi_r_t    r = '0;
    logic      rvalid = 1'b0;
    logic      rready;
    logic      commit_valid;
    word_t     commit_pc;
    reg_addr_t commit_rd;
    word_t     commit_data;
    logic      commit_wen;
    logic      halted;
    logic      fetch_err;

    int         seed = 32'hebdd_73d7;
    word_t      mem [PROG_LEN];
    int         err_fetch = -1;
    int         fetch_num;
    logic [1:0] ar_cnt;
    logic [1:0] r_cnt;
    logic       r_pending;
    word_t      r_addr;
    int         bench_errors = 0;
    int         error_count;
    int         commit_count;

    always #5 clk = ~clk;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) u_rv_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_wen   (commit_wen),
        .halted       (halted),
        .fetch_err    (fetch_err)
    );

    rv_core_checker #(
        .RESET_PC (RESET_PC)
    ) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_wen   (commit_wen),
        .halted       (halted),
        .fetch_err    (fetch_err),
        .error_count  (error_count),
        .commit_count (commit_count)
    );

    function automatic logic [1:0] random_delay();
        logic [31:0] v;
        v = $random(seed);
        return v[1:0];
    endfunction

    function automatic word_t read_word(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off[1:0] != 2'b00 || off >= PROG_LEN * 4) begin
            $display("%0t ns: instruction fetch at %h lies outside the program", $time, addr);
            bench_errors++;
            return EBREAK_INST;
        end
        return mem[off[6:2]];
    endfunction

    // memory model, random wait states on both channels
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            r         <= '0;
            ar_cnt    <= 2'd0;
            r_cnt     <= 2'd0;
            r_pending <= 1'b0;
            r_addr    <= '0;
            fetch_num <= 0;
        end else begin
            if (arvalid && arready) begin
                arready   <= 1'b0;
                ar_cnt    <= random_delay();
                r_cnt     <= random_delay();
                r_pending <= 1'b1;
                r_addr    <= ar.araddr;
            end else if (ar_cnt != 2'd0) begin
                ar_cnt <= ar_cnt - 2'd1;
            end else begin
                arready <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid    <= 1'b0;
                r_pending <= 1'b0;
                fetch_num <= fetch_num + 1;
            end else if (r_pending && !rvalid) begin
                if (r_cnt != 2'd0) begin
                    r_cnt <= r_cnt - 2'd1;
                end else begin
                    rvalid  <= 1'b1;
                    r.rdata <= read_word(r_addr);
                    r.rresp <= (fetch_num == err_fetch) ? 2'b10 : 2'b00;
                end
            end
        end
    end

    function automatic logic [6:0] unsupported_opcode(input logic [1:0] sel);
        case (sel)
            2'd0:    return 7'b0000011;
            2'd1:    return 7'b0100011;
            2'd2:    return 7'b1100011;
            default: return 7'b0001111;
        endcase
    endfunction

    // forward jumps only, so every program reaches the final ebreak
    task automatic gen_program(input logic with_jal);
        logic [31:0] v;
        logic [31:0] v2;
        logic [20:0] joff;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        int          target;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            v   = $random(seed);
            v2  = $random(seed);
            rd  = {2'b00, v[5:3]};
            rs1 = {2'b00, v[8:6]};
            rs2 = {2'b00, v[11:9]};
            case (v[2:0])
                3'd0, 3'd1: mem[i] = {v[31:20], rs1, 3'b000, rd, OPC_IMM_C};
                3'd2, 3'd3: mem[i] = {7'b0000000, rs2, rs1, 3'b000, rd, OPC_CALC};
                3'd4:       mem[i] = {v[31:12], rd, OPC_LUI};
                3'd5:       mem[i] = {v[31:12], rd, OPC_AUIPC};
                3'd6: begin
                    if (with_jal) begin
                        target  = i + 1 + int'(v2[15:0]) % (PROG_LEN - 1 - i);
                        joff    = 21'((target - i) * 4);
                        mem[i]  = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
                    end else begin
                        mem[i] = {v[31:20], rs1, 3'b000, rd, OPC_IMM_C};
                    end
                end
                default:    mem[i] = {v[31:7], unsupported_opcode(v2[1:0])};
            endcase
        end
        mem[PROG_LEN - 1] = EBREAK_INST;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_for_halt();
        @(negedge clk);
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic        err_test;
        int          errors_before;
        int          commits_before;
        int          test_errors;
        int          failed_tests;
        failed_tests = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            // every fourth test ends on a bad fetch response
            err_test = (t % 4 == 3);
            gen_program(!err_test);
            v         = $random(seed);
            err_fetch = err_test ? 1 + int'(v[15:0]) % (PROG_LEN - 3) : -1;
            errors_before  = error_count + bench_errors;
            commits_before = commit_count;
            apply_reset();
            wait_for_halt();
            repeat (8) @(posedge clk);
            if (err_test && fetch_err !== 1'b1) begin
                $display("test %0d: the bad fetch response was not reported", t);
                bench_errors++;
            end
            if (commit_count == commits_before) begin
                $display("test %0d: no instruction committed", t);
                bench_errors++;
            end
            test_errors = error_count + bench_errors - errors_before;
            if (test_errors != 0) begin
                failed_tests++;
            end
            $display("test %0d (%s): %s, %0d commits, %0d errors", t,
                     err_test ? "fetch error" : "ebreak", (test_errors == 0) ? "ok" : "mismatch",
                     commit_count - commits_before, test_errors);
        end
        $display("tests: %0d, tests with errors: %0d, commits checked: %0d, errors: %0d",
                 NUM_TESTS, failed_tests, commit_count, error_count + bench_errors);
        if (failed_tests == 0 && error_count + bench_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // one-hot, all zero gives a zero result
    typedef logic [1:0]  alu_op_t;

    localparam int ALU_ADD = 0;
    localparam int ALU_LUI = 1;

    // rv32i major opcodes
    localparam logic [6:0] OPC_IMM_C  = 7'b0010011;
    localparam logic [6:0] OPC_CALC   = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // unprivileged, secure, instruction access
    localparam logic [2:0] ARPROT_INST = 3'b100;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    typedef struct packed {
        word_t     alu_src1;
        word_t     alu_src2;
        reg_addr_t alu_des;
        alu_op_t   alu_op;
        logic      wen;
        logic      jump;
        logic      halt;
    } decode_t;

    typedef struct packed {
        word_t      araddr;
        logic [2:0] arprot;
    } axi_ar_t;

    typedef struct packed {
        word_t      rdata;
        logic [1:0] rresp;
    } axi_r_t;

    typedef enum logic [2:0] {
        F_IDLE,
        F_AR,
        F_R,
        F_EXEC,
        F_HALT
    } fetch_state_e;

endpackage

// ==== idu/rv_idu.sv ====
module rv_idu (
    input  rv_core_pkg::word_t     inst,
    input  rv_core_pkg::word_t     pc,
    input  rv_core_pkg::word_t     reg_rdata1,
    input  rv_core_pkg::word_t     reg_rdata2,
    output rv_core_pkg::reg_addr_t reg_raddr1,
    output rv_core_pkg::reg_addr_t reg_raddr2,
    output rv_core_pkg::decode_t   dec
);
    import rv_core_pkg::*;

    // instruction fields
    logic [6:0] opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic is_addi;
    logic is_add;
    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_ebreak;

    word_t imm_i;
    word_t imm_u;
    word_t imm;

    logic src1_pc;
    logic src2_imm;
    logic use_rs1;
    logic use_rs2;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign is_addi   = (opcode == OPC_IMM_C) && (funct3 == 3'b000);
    assign is_add    = (opcode == OPC_CALC) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    // full match, ecall and csr ops fall through as unsupported
    assign is_ebreak = (opcode == OPC_SYSTEM) && (inst[31:7] == 25'h0002000);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    // i-type for addi, u-type for lui and auipc
    assign imm = is_addi ? imm_i : imm_u;

    assign src1_pc  = is_auipc || is_jal;
    assign src2_imm = is_addi || is_lui || is_auipc;

    // unused read ports park on x0
    assign use_rs1 = is_addi || is_add;
    assign use_rs2 = is_add;

    assign reg_raddr1 = use_rs1 ? rs1 : '0;
    assign reg_raddr2 = use_rs2 ? rs2 : '0;

    always_comb begin
        dec.alu_src1 = src1_pc ? pc : reg_rdata1;
        if (is_jal) begin
            // link value is pc + 4
            dec.alu_src2 = 32'd4;
        end else if (src2_imm) begin
            dec.alu_src2 = imm;
        end else begin
            dec.alu_src2 = reg_rdata2;
        end
        dec.alu_des          = rd;
        dec.alu_op           = '0;
        dec.alu_op[ALU_ADD]  = is_addi || is_add || is_auipc || is_jal;
        dec.alu_op[ALU_LUI]  = is_lui;
        dec.wen              = is_addi || is_add || is_lui || is_auipc || is_jal;
        dec.jump             = is_jal;
        dec.halt             = is_ebreak;
    end

endmodule

// ==== ifu/rv_ifu.sv ====
module rv_ifu #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output rv_core_pkg::axi_ar_t ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  rv_core_pkg::axi_r_t  r,
    input  logic                 rvalid,
    output logic                 rready,
    output rv_core_pkg::word_t   inst,
    output rv_core_pkg::word_t   pc,
    output logic                 exec,
    input  rv_core_pkg::word_t   next_pc,
    input  logic                 halt_req,
    output logic                 fetch_err
);
    import rv_core_pkg::*;

    fetch_state_e state;
    fetch_state_e state_nxt;
    word_t        pc_q;
    word_t        inst_q;
    logic         err_q;
    logic         r_fire;
    logic         r_bad;

    // rready is only high in F_R
    assign r_fire = rvalid && rready;
    assign r_bad  = (r.rresp != RESP_OKAY);

    always_comb begin
        state_nxt = state;
        unique case (state)
            F_IDLE: state_nxt = F_AR;
            F_AR: begin
                if (arready) begin
                    state_nxt = F_R;
                end
            end
            F_R: begin
                if (r_fire) begin
                    state_nxt = r_bad ? F_HALT : F_EXEC;
                end
            end
            F_EXEC: state_nxt = halt_req ? F_HALT : F_AR;
            F_HALT: state_nxt = F_HALT;
            default: state_nxt = F_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
            pc_q  <= RESET_PC;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // pc only moves after EXEC so araddr holds during AR wait
            if (state == F_EXEC) begin
                pc_q <= next_pc;
            end
            if (r_fire && r_bad) begin
                err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire && !r_bad) begin
            inst_q <= r.rdata;
        end
    end

    assign ar.araddr = pc_q;
    assign ar.arprot = ARPROT_INST;
    assign arvalid   = (state == F_AR);
    assign rready    = (state == F_R);
    assign exec      = (state == F_EXEC);
    assign inst      = inst_q;
    assign pc        = pc_q;
    assign fetch_err = err_q;

endmodule

// ==== rtl/rv_core_top.sv ====
module rv_core_top #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h8000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output rv_core_pkg::axi_ar_t   ar,
    output logic                   arvalid,
    input  logic                   arready,
    input  rv_core_pkg::axi_r_t    r,
    input  logic                   rvalid,
    output logic                   rready,
    output logic                   commit_valid,
    output rv_core_pkg::word_t     commit_pc,
    output rv_core_pkg::reg_addr_t commit_rd,
    output rv_core_pkg::word_t     commit_data,
    output logic                   commit_wen,
    output logic                   halted,
    output logic                   fetch_err
);
    import rv_core_pkg::*;

    word_t     inst;
    word_t     pc;
    logic      exec;
    word_t     next_pc;
    logic      halt_req;
    reg_addr_t reg_raddr1;
    reg_addr_t reg_raddr2;
    word_t     reg_rdata1;
    word_t     reg_rdata2;
    decode_t   dec;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata;

    rv_ifu #(
        .RESET_PC (RESET_PC)
    ) u_ifu (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .inst      (inst),
        .pc        (pc),
        .exec      (exec),
        .next_pc   (next_pc),
        .halt_req  (halt_req),
        .fetch_err (fetch_err)
    );

    rv_idu u_idu (
        .inst       (inst),
        .pc         (pc),
        .reg_rdata1 (reg_rdata1),
        .reg_rdata2 (reg_rdata2),
        .reg_raddr1 (reg_raddr1),
        .reg_raddr2 (reg_raddr2),
        .dec        (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (reg_raddr1),
        .raddr2 (reg_raddr2),
        .rdata1 (reg_rdata1),
        .rdata2 (reg_rdata2),
        .we     (reg_we),
        .waddr  (reg_waddr),
        .wdata  (reg_wdata)
    );

    rv_exu u_exu (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .inst         (inst),
        .pc           (pc),
        .exec         (exec),
        .fetch_err    (fetch_err),
        .reg_we       (reg_we),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .next_pc      (next_pc),
        .halt_req     (halt_req),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_wen   (commit_wen),
        .halted       (halted)
    );

endmodule

// ==== rtl/rv_exu.sv ====
module rv_exu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::decode_t   dec,
    input  rv_core_pkg::word_t     inst,
    input  rv_core_pkg::word_t     pc,
    input  logic                   exec,
    input  logic                   fetch_err,
    output logic                   reg_we,
    output rv_core_pkg::reg_addr_t reg_waddr,
    output rv_core_pkg::word_t     reg_wdata,
    output rv_core_pkg::word_t     next_pc,
    output logic                   halt_req,
    output logic                   commit_valid,
    output rv_core_pkg::word_t     commit_pc,
    output rv_core_pkg::reg_addr_t commit_rd,
    output rv_core_pkg::word_t     commit_data,
    output logic                   commit_wen,
    output logic                   halted
);
    import rv_core_pkg::*;

    word_t alu_res;
    word_t imm_j;
    logic  halt_q;

    assign alu_res = ({32{dec.alu_op[ALU_ADD]}} & (dec.alu_src1 + dec.alu_src2)) |
                     ({32{dec.alu_op[ALU_LUI]}} & dec.alu_src2);

    // src2 carries the link constant, so the jump target comes from inst
    assign imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign next_pc = dec.jump ? (pc + imm_j) : (pc + 32'd4);

    assign reg_we    = exec && dec.wen;
    assign reg_waddr = dec.alu_des;
    assign reg_wdata = alu_res;
    assign halt_req  = exec && dec.halt;

    assign commit_valid = exec;
    assign commit_pc    = pc;
    assign commit_rd    = dec.alu_des;
    assign commit_data  = alu_res;
    assign commit_wen   = reg_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (halt_req) begin
            halt_q <= 1'b1;
        end
    end

    // halted rises together with fetch_err
    assign halted = halt_q || fetch_err;

endmodule

// ==== rtl/rv_regfile.sv ====
module rv_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::reg_addr_t raddr1,
    input  rv_core_pkg::reg_addr_t raddr2,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t waddr,
    input  rv_core_pkg::word_t     wdata
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rv_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// ==== rv_core.f ====
common/rv_core_pkg.sv
ifu/rv_ifu.sv
idu/rv_idu.sv
rtl/rv_regfile.sv
rtl/rv_exu.sv
rtl/rv_core_top.sv
bench/rv_core_checker.sv
bench/tb_rv_core.sv
